// File: verif/decodeVectors.mem
// instr        flags const            len memSz weMask, two vectors per group
// flags msb first: alu alu0 fpu flowCtrl br jmp jal ret brk irq bt load store mem imm cmp rfw
000000486004 10005 0000000000000012 4 3 FF
FFFFFFC0A04A 18005 FFFFFFFFFFFFFFF0 6 3 FF
0000E800E002 18001 FFFFFFFFFFFFFA00 4 3 FF
0000B0000302 18000 FFFFFFFFFFFFEC00 4 3 FF
00000014800F 04000 0000000000000005 4 3 FF
0000050CC006 10006 0000000000000143 4 3 00
0000007C4013 1002D 000000000000001F 4 0 FF
123400802060 1002D 00000000048D0020 6 1 FF
000081052020 1002D FFFFFFFFFFFFE041 4 2 FF
000002014020 1002D 0000000000000080 4 3 FF
000001A8A015 1001C 0000000000000065 4 0 FF
80000083E064 1001C FFFFFFFFE000003F 6 1 FF
0000FD000024 1001C FFFFFFFFFFFFFF40 4 2 FF
00000A004024 1001C 0000000000000282 4 3 FF
000000106030 03000 0000000000000004 4 3 FF
0000FFFC0004 10004 FFFFFFFFFFFFFFFF 4 3 FF
000000082018 02445 0000000000000002 4 3 FF
000000486004 10005 0000000000000012 4 3 FF
00010003E069 02245 0000000000004000 6 3 FF
0000007C4013 1002D 000000000000001F 4 0 FF
000000000100 021C0 0000000000000000 4 3 FF
00000004800E 18005 0000000000000001 4 3 FF
00FF00000068 02800 00000000003FC000 6 3 FF
000010010002 10001 0000000000000400 4 3 FF

// File: list.f
verilog/ft64IsaPkg.sv
verilog/decodePkg.sv
verilog/fetchGroupFeeder.sv
verilog/insnDecodeLane.sv
verilog/decodeGroupCollector.sv
verilog/ft64DecodeTop.sv
verif/tbDecodeTop.sv

// File: verif/tbDecodeTop.sv
/*
 * Testbench for the multi-lane decode stage
 *   vector file loading and group stimulus
 *   expected ids, squashing and latency model
 *   field checks and final report
 */
`timescale 1ns/1ps
`default_nettype none

module tbDecodeTop
    import ft64IsaPkg::*, decodePkg::*;
();

    localparam int LANES      = 2;
    localparam int NUM_VEC    = 24;
    localparam int VEC_COLS   = 6;
    localparam int RST_CYCLES = 16;
    localparam int LATENCY    = 3;
    localparam int WAIT_LIMIT = 50;
    localparam int PASSES     = 2;

    logic                       clk;
    logic                       rst_i;
    logic                       groupValid_i;
    instrT     [LANES-1:0]      group_i;
    decodeRecT [LANES-1:0]      dec_o;
    logic                       groupValid_o;
    logic [$clog2(LANES+1)-1:0] liveCount_o;

    // Per vector the instr, flags, const, length, memSz and weMask words
    logic [63:0] vecMem [0:NUM_VEC*VEC_COLS-1];

    // Groups in flight where base -1 marks an idle cycle
    int      pendBase[$];
    instrIdT pendId[$];
    int      pendDue[$];

    int      cycle;
    int      errors;
    int      checks;
    instrIdT nextId;

    ft64DecodeTop #(
        .LANES        (LANES)
    ) u_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .groupValid_i (groupValid_i),
        .group_i      (group_i),
        .dec_o        (dec_o),
        .groupValid_o (groupValid_o),
        .liveCount_o  (liveCount_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // Checking
    // ====================
    task automatic checkField(input string name, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            errors++;
            $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
        end
    endtask

    // Unconditional change of flow ends the useful part of a group
    function automatic logic groupEnds(input instrT insn);
        return (insn[5:0] == OP_JMP) || (insn[5:0] == OP_JAL)
               || (insn[5:0] == OP_RET) || (insn[5:0] == OP_BRK);
    endfunction

    task automatic checkOutputs(input int base, input instrIdT id0);
        logic      squash;
        logic      noWrite;
        int        live;
        int        v;
        instrT     insn;
        decodeRecT r;
        string     lane;
        squash = (base < 0);
        live   = 0;
        checkField("groupValid_o", base >= 0, groupValid_o);
        for (int k = 0; k < LANES; k++) begin
            r    = dec_o[k];
            lane = $sformatf("dec_o[%0d]", k);
            checkField({lane, ".valid"}, !squash, r.valid);
            if (!squash) begin
                v    = (base + k) * VEC_COLS;
                insn = vecMem[v][47:0];
                live++;
                checkField({lane, ".id"}, instrIdT'(id0 + k), r.id);
                checkField({lane, ".flags"}, vecMem[v+1][16:1],
                           {r.alu, r.alu0, r.fpu, r.flowCtrl, r.br, r.jmp, r.jal, r.ret,
                            r.brk, r.irq, r.bt, r.load, r.store, r.mem, r.imm, r.cmp});
                // Stores, branches and r0 targets never write
                noWrite = (insn[17:13] == 5'd0) || (insn[5:0] == OP_SB)
                          || (insn[5:0] == OP_SX) || (insn[5:0] == OP_BCC)
                          || (insn[5:0] == OP_BEQI);
                checkField({lane, ".rfw"}, vecMem[v+1][0] && !noWrite, r.rfw);
                checkField({lane, ".rt"}, insn[17:13], r.rt);
                checkField({lane, ".immConst"}, vecMem[v+2], r.immConst);
                checkField({lane, ".length"}, vecMem[v+3], r.length);
                checkField({lane, ".memSz"}, vecMem[v+4], r.memSz);
                checkField({lane, ".weMask"}, vecMem[v+5], r.weMask);
                squash = groupEnds(insn);
            end
        end
        checkField("liveCount_o", live, liveCount_o);
    endtask

    // ====================
    // Stimulus
    // ====================
    // Check what is due on one falling edge then drive the next input
    task automatic stepCycle(input int base, input logic track);
        @(negedge clk);
        cycle++;
        if (pendDue.size() > 0 && pendDue[0] == cycle) begin
            checkOutputs(pendBase[0], pendId[0]);
            void'(pendBase.pop_front());
            void'(pendId.pop_front());
            void'(pendDue.pop_front());
        end
        groupValid_i = (base >= 0);
        for (int k = 0; k < LANES; k++) begin
            group_i[k] = (base >= 0) ? vecMem[(base + k) * VEC_COLS][47:0] : '0;
        end
        if (track) begin
            pendBase.push_back(base);
            pendId.push_back(nextId);
            pendDue.push_back(cycle + LATENCY);
        end
        if (base >= 0) begin
            nextId = nextId + instrIdT'(LANES);
        end
    endtask

    task automatic applyReset(output bit ok);
        int waited;
        rst_i = 1'b1;
        for (int c = 0; c < RST_CYCLES; c++) begin
            @(negedge clk);
            // Outputs are known once reset has been clocked in
            if (c >= 2) begin
                checkOutputs(-1, '0);
            end
        end
        rst_i  = 1'b0;
        waited = 0;
        while (groupValid_o !== 1'b0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = (groupValid_o === 1'b0);
        if (!ok) begin
            $display("Timeout: groupValid_o did not settle low after reset");
        end
        cycle = 0;
        // Cycles right after reset must stay empty
        for (int c = 1; c <= LATENCY; c++) begin
            pendBase.push_back(-1);
            pendId.push_back('0);
            pendDue.push_back(c);
        end
    endtask

    // Second pass takes the ids past the 5-bit wrap
    task automatic runGroups();
        int gap;
        for (int p = 0; p < PASSES; p++) begin
            for (int g = 0; g < NUM_VEC / LANES; g++) begin
                stepCycle(g * LANES, 1'b1);
                // First groups back to back and random gaps later
                gap = (p == 0 && g < 4) ? 0 : int'($urandom % 3);
                for (int i = 0; i < gap; i++) begin
                    stepCycle(-1, 1'b1);
                end
            end
        end
    endtask

    task automatic drainPipe(output bit ok);
        int waited;
        waited = 0;
        while (pendDue.size() > 0 && waited < WAIT_LIMIT) begin
            stepCycle(-1, 1'b0);
            waited++;
        end
        ok = (pendDue.size() == 0);
        if (!ok) begin
            $display("Timeout: %0d groups never came out of the DUT", pendDue.size());
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin : mainFlow
        bit ok;
        void'($urandom(91));
        rst_i        = 1'b1;
        groupValid_i = 1'b0;
        group_i      = '0;
        errors       = 0;
        checks       = 0;
        cycle        = 0;
        nextId       = '0;
        $readmemh("verif/decodeVectors.mem", vecMem);
        ok = !$isunknown(vecMem[NUM_VEC*VEC_COLS-1]);
        if (!ok) begin
            $display("Vector file is missing or shorter than expected");
        end else begin
            applyReset(ok);
        end
        if (ok) begin
            runGroups();
            drainPipe(ok);
        end
        if (!ok) begin
            errors++;
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ft64DecodeTop.sv
/*
 * Multi-lane decode stage top
 *   fetch group feeder, decode lanes, group collector
 */
`timescale 1ns/1ps
`default_nettype none

module ft64DecodeTop
    import ft64IsaPkg::*, decodePkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        groupValid_i,
    input  instrT     [LANES-1:0]       group_i,
    output decodeRecT [LANES-1:0]       dec_o,
    output logic                        groupValid_o,
    output logic [$clog2(LANES+1)-1:0]  liveCount_o
);

    fetchSlotT [LANES-1:0] slots;
    decodeRecT [LANES-1:0] recs;

    fetchGroupFeeder #(
        .LANES        (LANES)
    ) u_feeder (
        .clk          (clk),
        .rst_i        (rst_i),
        .groupValid_i (groupValid_i),
        .group_i      (group_i),
        .slot_o       (slots)
    );

    // One decoder per slot
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        insnDecodeLane u_lane (
            .clk    (clk),
            .rst_i  (rst_i),
            .slot_i (slots[k]),
            .rec_o  (recs[k])
        );
    end

    decodeGroupCollector #(
        .LANES        (LANES)
    ) u_collector (
        .clk          (clk),
        .rst_i        (rst_i),
        .rec_i        (recs),
        .dec_o        (dec_o),
        .groupValid_o (groupValid_o),
        .liveCount_o  (liveCount_o)
    );

endmodule

`default_nettype wire

// File: verilog/decodeGroupCollector.sv
/*
 * Decode group output stage
 *   squashes slots behind an unconditional flow change
 *   counts live slots and registers the group
 */
`timescale 1ns/1ps
`default_nettype none

module decodeGroupCollector
    import decodePkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  decodeRecT [LANES-1:0]           rec_i,
    output decodeRecT [LANES-1:0]           dec_o,
    output logic                            groupValid_o,
    output logic [$clog2(LANES+1)-1:0]      liveCount_o
);

    localparam int CNT_W = $clog2(LANES + 1);

    decodeRecT [LANES-1:0] squashed;
    logic                  flowSeen;
    logic [CNT_W-1:0]      liveD;

    // ====================
    // Squash and count
    // ====================
    always_comb begin
        flowSeen = 1'b0;
        liveD    = '0;
        for (int k = 0; k < LANES; k++) begin
            squashed[k] = rec_i[k];
            // Fetched past a taken jump, call return or break
            if (flowSeen) begin
                squashed[k].valid = 1'b0;
            end
            if (squashed[k].valid && (rec_i[k].jmp || rec_i[k].jal
                                      || rec_i[k].ret || rec_i[k].brk)) begin
                flowSeen = 1'b1;
            end
            liveD = liveD + CNT_W'(squashed[k].valid);
        end
    end

    // ====================
    // Output registers
    // ====================
    always_ff @(posedge clk) begin
        dec_o <= squashed;
        if (rst_i) begin
            groupValid_o <= 1'b0;
            liveCount_o  <= '0;
            for (int k = 0; k < LANES; k++) begin
                dec_o[k].valid <= 1'b0;
            end
        end else begin
            // Lane 0 is never squashed
            groupValid_o <= rec_i[0].valid;
            liveCount_o  <= liveD;
        end
    end

endmodule

`default_nettype wire

// File: verilog/insnDecodeLane.sv
/*
 * Single decode lane
 *   classifies one instruction word
 *   extracts constant, length, target and write mask
 *   registers the decode record
 */
`timescale 1ns/1ps
`default_nettype none

module insnDecodeLane
    import ft64IsaPkg::*, decodePkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  fetchSlotT slot_i,
    output decodeRecT rec_o
);

    instrT      insn;
    logic [5:0] opc;
    logic [5:0] fn;
    logic [4:0] rtFld;
    logic       shortForm;
    logic       isRti;
    logic       wrCapable;
    decodeRecT  recD;

    assign insn      = slot_i.instr;
    assign opc       = insn[OPC_HI:OPC_LO];
    assign fn        = insn[FUNC_HI:FUNC_LO];
    assign rtFld     = insn[RT_HI:RT_LO];
    // R2 function field only meaningful in the 32-bit form
    assign shortForm = (insn[LEN_HI:LEN_LO] == 2'b00);
    assign isRti     = (opc == OP_R2) && (fn == FN_RTI);

    always_comb begin
        recD       = '0;
        recD.valid = slot_i.valid;
        recD.id    = slot_i.id;

        // ====================
        // Unit class
        // ====================
        recD.alu  = 1'b1;
        recD.alu0 = 1'b0;
        recD.fpu  = 1'b0;
        case (opc)
            OP_R2: begin
                recD.alu = !isRti;
                if (shortForm) begin
                    case (fn)
                        FN_MUL, FN_DIV, FN_MIN, FN_MAX: recD.alu0 = 1'b1;
                        default: recD.alu0 = 1'b0;
                    endcase
                end
            end
            OP_MULI, OP_DIVI: recD.alu0 = 1'b1;
            OP_BRK, OP_BCC, OP_BEQI, OP_JAL, OP_JMP, OP_CALL, OP_RET: recD.alu = 1'b0;
            OP_FLOAT: begin
                recD.alu = 1'b0;
                recD.fpu = 1'b1;
            end
            default: recD.alu = 1'b1;
        endcase

        // ====================
        // Flow control
        // ====================
        recD.br  = (opc == OP_BCC) || (opc == OP_BEQI);
        recD.jmp = (opc == OP_JMP);
        recD.jal = (opc == OP_JAL);
        recD.ret = (opc == OP_RET);
        recD.brk = (opc == OP_BRK);
        // Hardware interrupt is a BRK with a zero cause field
        recD.irq = (opc == OP_BRK) && (insn[25:21] == 5'd0);
        recD.flowCtrl = recD.br || recD.jmp || recD.jal || recD.ret || recD.brk
                        || isRti || (opc == OP_CALL);
        // Targets not known from the instruction alone
        recD.bt = recD.jal || recD.ret || recD.brk || isRti;

        // ====================
        // Memory
        // ====================
        recD.load  = (opc == OP_LB) || (opc == OP_LX);
        recD.store = (opc == OP_SB) || (opc == OP_SX);
        recD.mem   = recD.load || recD.store;
        case (opc)
            OP_LB, OP_SB: recD.memSz = MEM_BYTE;
            OP_LX, OP_SX: begin
                // One-hot size select, nothing set means hexi
                casez (insn[SZ_HI:SZ_LO])
                    3'b??1:  recD.memSz = MEM_WYDE;
                    3'b?10:  recD.memSz = MEM_TETRA;
                    3'b100:  recD.memSz = MEM_OCTA;
                    default: recD.memSz = MEM_HEXI;
                endcase
            end
            default: recD.memSz = MEM_OCTA;
        endcase

        // ====================
        // Immediate and compare
        // ====================
        case (opc)
            OP_ADDI, OP_ANDI, OP_ORI, OP_CMPI, OP_MULI, OP_DIVI,
            OP_LB, OP_LX, OP_SB, OP_SX, OP_JAL, OP_CALL, OP_RET:
                recD.imm = 1'b1;
            default:
                recD.imm = 1'b0;
        endcase
        recD.cmp    = (opc == OP_CMPI) || ((opc == OP_R2) && shortForm && (fn == FN_CMP));
        // Compares update predicates, not the register lanes
        recD.weMask = recD.cmp ? 8'h00 : 8'hFF;

        // Stores split the constant around the source register field
        if (recD.store) begin
            if (insn[LEN_LO]) begin
                recD.immConst = {{34{insn[47]}}, insn[47:SZ_LO], insn[RT_HI:RT_LO]};
            end else begin
                recD.immConst = {{50{insn[31]}}, insn[31:SZ_LO], insn[RT_HI:RT_LO]};
            end
        end else begin
            if (insn[LEN_LO]) begin
                recD.immConst = {{34{insn[47]}}, insn[47:18]};
            end else begin
                recD.immConst = {{50{insn[31]}}, insn[31:18]};
            end
        end

        // Length in bytes
        case (insn[LEN_HI:LEN_LO])
            2'b00:   recD.length = 3'd4;
            2'b01:   recD.length = 3'd6;
            default: recD.length = 3'd2;
        endcase

        // ====================
        // Register write
        // ====================
        recD.rt = rtFld;
        case (opc)
            OP_R2: begin
                case (fn)
                    FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_MIN, FN_MAX: wrCapable = 1'b1;
                    default: wrCapable = 1'b0;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_MULI, OP_DIVI,
            OP_JAL, OP_CALL, OP_RET, OP_LB, OP_LX:
                wrCapable = 1'b1;
            default:
                wrCapable = 1'b0;
        endcase
        // r0 is hardwired zero
        recD.rfw = wrCapable && (rtFld != 5'd0);
    end

    always_ff @(posedge clk) begin
        rec_o <= recD;
        if (rst_i) begin
            rec_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetchGroupFeeder.sv
/*
 * Fetch group input register
 *   registers LANES instruction words as fetch slots
 *   tags each slot with a sequential instruction id
 */
`timescale 1ns/1ps
`default_nettype none

module fetchGroupFeeder
    import ft64IsaPkg::*, decodePkg::*;
#(
    parameter int LANES = 2
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     groupValid_i,
    input  instrT     [LANES-1:0]    group_i,
    output fetchSlotT [LANES-1:0]    slot_o
);

    // Id given to slot 0 of the next group
    instrIdT idBase;

    // ====================
    // Id counter
    // ====================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            idBase <= '0;
        end else if (groupValid_i) begin
            // Natural 5-bit wrap
            idBase <= idBase + instrIdT'(LANES);
        end
    end

    // ====================
    // Slot registers
    // ====================
    always_ff @(posedge clk) begin
        for (int k = 0; k < LANES; k++) begin
            slot_o[k].valid <= groupValid_i;
            slot_o[k].id    <= idBase + instrIdT'(k);
            slot_o[k].instr <= group_i[k];
        end
        if (rst_i) begin
            for (int k = 0; k < LANES; k++) begin
                slot_o[k].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/decodePkg.sv
/*
 * Decode pipeline records
 *   instruction id type
 *   fetch slot and decode record structs
 */
`default_nettype none

package decodePkg;

    import ft64IsaPkg::*;

    // Sequential id, wraps at 32
    typedef logic [4:0] instrIdT;

    // One slot of a registered fetch group
    typedef struct packed {
        logic    valid;
        instrIdT id;
        instrT   instr;
    } fetchSlotT;

    // Decoded instruction
    typedef struct packed {
        logic        valid;
        instrIdT     id;
        // Unit class
        logic        alu;
        logic        alu0;
        logic        fpu;
        // Flow control
        logic        flowCtrl;
        logic        br;
        logic        jmp;
        logic        jal;
        logic        ret;
        logic        brk;
        logic        irq;
        logic        bt;
        // Memory ops
        logic        load;
        logic        store;
        logic        mem;
        logic        imm;
        logic        cmp;
        logic        rfw;
        memSizeE     memSz;
        logic [2:0]  length;
        logic [4:0]  rt;
        logic [7:0]  weMask;
        logic [63:0] immConst;
    } decodeRecT;

endpackage

`default_nettype wire

// File: verilog/ft64IsaPkg.sv
/*
 * Instruction set definitions for the decoder
 *   instruction word type
 *   opcode and R2 function codes
 *   instruction field bit positions
 *   memory access size encoding
 */
`default_nettype none

package ft64IsaPkg;

    // One 48-bit instruction word
    typedef logic [47:0] instrT;

    // ====================
    // Major opcodes
    // ====================
    localparam logic [5:0] OP_BRK   = 6'h00;
    localparam logic [5:0] OP_R2    = 6'h02;
    localparam logic [5:0] OP_ADDI  = 6'h04;
    localparam logic [5:0] OP_CMPI  = 6'h06;
    localparam logic [5:0] OP_ANDI  = 6'h08;
    localparam logic [5:0] OP_ORI   = 6'h09;
    localparam logic [5:0] OP_MULI  = 6'h0A;
    localparam logic [5:0] OP_DIVI  = 6'h0E;
    localparam logic [5:0] OP_FLOAT = 6'h0F;
    localparam logic [5:0] OP_LB    = 6'h13;
    localparam logic [5:0] OP_SB    = 6'h15;
    localparam logic [5:0] OP_JAL   = 6'h18;
    localparam logic [5:0] OP_CALL  = 6'h19;
    localparam logic [5:0] OP_LX    = 6'h20;
    localparam logic [5:0] OP_SX    = 6'h24;
    localparam logic [5:0] OP_JMP   = 6'h28;
    localparam logic [5:0] OP_RET   = 6'h29;
    localparam logic [5:0] OP_BCC   = 6'h30;
    localparam logic [5:0] OP_BEQI  = 6'h32;

    // ====================
    // R2 function codes
    // ====================
    localparam logic [5:0] FN_ADD = 6'h04;
    localparam logic [5:0] FN_SUB = 6'h05;
    localparam logic [5:0] FN_CMP = 6'h06;
    localparam logic [5:0] FN_MIN = 6'h2C;
    localparam logic [5:0] FN_MAX = 6'h2D;
    localparam logic [5:0] FN_RTI = 6'h32;
    localparam logic [5:0] FN_MUL = 6'h3A;
    localparam logic [5:0] FN_DIV = 6'h3E;

    // ====================
    // Field positions
    // ====================
    localparam int OPC_LO  = 0;
    localparam int OPC_HI  = 5;
    // Length bits, bit 6 also selects the 48-bit constant form
    localparam int LEN_LO  = 6;
    localparam int LEN_HI  = 7;
    localparam int RT_LO   = 13;
    localparam int RT_HI   = 17;
    localparam int SZ_LO   = 23;
    localparam int SZ_HI   = 25;
    localparam int FUNC_LO = 26;
    localparam int FUNC_HI = 31;

    // Memory access size
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'd0,
        MEM_WYDE  = 3'd1,
        MEM_TETRA = 3'd2,
        MEM_OCTA  = 3'd3,
        MEM_HEXI  = 3'd4
    } memSizeE;

endpackage

`default_nettype wire
